/* all.f */
+incdir+design
design/mem_data_pkg.sv
design/mem_ctrl_pkg.sv
design/word_fifo.sv
design/txrx_buffer_l2_l1.sv
design/l2_wb_master.sv
design/l2_store.sv
design/l1_l2_path_top.sv
dv/l1_l2_path_props.sv
dv/l1_l2_path_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the L1/L2 path testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

TOP=l1_l2_path_tb
BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module "$TOP" -f all.f --Mdir "$BUILD_DIR" -o "$TOP"
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

# keep running past assertion errors so the testbench prints its verdict
"./$BUILD_DIR/$TOP" +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Simulation failed" "$LOG"; then
	exit 1
fi
if ! grep -q "Simulation completed successfully" "$LOG"; then
	echo "no verdict found in $LOG"
	exit 1
fi
exit 0

/* dv/l1_l2_path_tb.sv */
`timescale 1ns/100ps

`include "mem_defs.svh"

module l1_l2_path_tb;

	localparam int CLK_PERIOD = 4;
	localparam int N_WRITES   = 12;
	// pushes, requests, pops and resets over all phases
	localparam int OP_COUNT = 4 * N_WRITES + 2 + 2 * (`BUF_DEPTH + 1)
		+ (`BUF_DEPTH + 1) + 3;
	localparam int WATCHDOG_CYCLES = OP_COUNT * 20 + 100;

	logic                 clock_bus_i = 1'b0;
	logic                 reset_i;
	logic                 req_i;
	logic                 rw_i;
	mem_data_pkg::waddr_t add_i;
	logic                 write_en_i;
	logic                 read_ack_i;
	mem_data_pkg::word_t  data_i;
	logic                 ready_req_o;
	logic                 ready_write_o;
	logic                 ready_read_o;
	mem_data_pkg::word_t  data_o;
	mem_ctrl_pkg::exc_t   exception_bus_o;

	// shadow of the L2 store, zero where never written
	mem_data_pkg::word_t  shadow [`L2_WORDS];
	bit                   written [`L2_WORDS];
	// outstanding reads in request order
	mem_data_pkg::word_t  exp_q [$];
	mem_data_pkg::waddr_t exp_adr_q [$];
	mem_data_pkg::waddr_t wr_adr [N_WRITES];
	int                   errors = 0;

	always #(CLK_PERIOD / 2) clock_bus_i = ~clock_bus_i;

	l1_l2_path_top i_dut (
		.clock_bus_i     (clock_bus_i),
		.reset_i         (reset_i),
		.exception_bus_o (exception_bus_o),
		.req_i           (req_i),
		.rw_i            (rw_i),
		.add_i           (add_i),
		.write_en_i      (write_en_i),
		.read_ack_i      (read_ack_i),
		.data_i          (data_i),
		.ready_req_o     (ready_req_o),
		.ready_write_o   (ready_write_o),
		.ready_read_o    (ready_read_o),
		.data_o          (data_o)
	);

	// ------------------------------------------------------------
	// helpers, all start and end on a falling edge
	// ------------------------------------------------------------
	task automatic check_value(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		assert (actual === expected) else begin
			errors++;
			$display("[FAIL] %s expected %h actual %h", name, expected, actual);
		end
	endtask

	task automatic apply_reset();
		reset_i = 1'b0;
		repeat (2) @(negedge clock_bus_i);
		reset_i = 1'b1;
		// store comes back as all zero
		for (int i = 0; i < `L2_WORDS; i++) begin
			shadow[i]  = '0;
			written[i] = 1'b0;
		end
		@(negedge clock_bus_i);
		check_value("exception_bus_o", 32'(exception_bus_o), 0);
		check_value("ready_read_o", 32'(ready_read_o), 0);
		check_value("ready_write_o", 32'(ready_write_o), 1);
	endtask

	task automatic push_word(input mem_data_pkg::word_t data);
		write_en_i = 1'b1;
		data_i     = data;
		@(negedge clock_bus_i);
		write_en_i = 1'b0;
	endtask

	task automatic issue_request(input logic rw, input mem_data_pkg::waddr_t addr);
		req_i = 1'b1;
		rw_i  = rw;
		add_i = addr;
		// ready only moves on the rising edge
		while (!ready_req_o) begin
			@(negedge clock_bus_i);
		end
		@(negedge clock_bus_i);
		req_i = 1'b0;
		if (!rw) begin
			exp_q.push_back(shadow[addr]);
			exp_adr_q.push_back(addr);
		end
	endtask

	task automatic pop_and_check();
		mem_data_pkg::word_t  exp;
		mem_data_pkg::waddr_t adr;
		while (!ready_read_o) begin
			@(negedge clock_bus_i);
		end
		if (exp_q.size() == 0) begin
			errors++;
			$display("read word arrived with no read outstanding");
		end else begin
			exp = exp_q.pop_front();
			adr = exp_adr_q.pop_front();
			assert (data_o === exp) else begin
				errors++;
				$display("[FAIL] data_o addr %h expected %h actual %h", adr, exp, data_o);
			end
		end
		read_ack_i = 1'b1;
		@(negedge clock_bus_i);
		read_ack_i = 1'b0;
	endtask

	// ------------------------------------------------------------
	// stimulus
	// ------------------------------------------------------------
	initial begin
		mem_data_pkg::waddr_t a;
		mem_data_pkg::word_t  d;
		int                   prop_errs;
		void'($urandom(32'h0151710f));
		reset_i    = 1'b0;
		req_i      = 1'b0;
		rw_i       = 1'b0;
		add_i      = '0;
		write_en_i = 1'b0;
		read_ack_i = 1'b0;
		data_i     = '0;
		apply_reset();

		// random writes then reads of the same addresses
		for (int i = 0; i < N_WRITES; i++) begin
			a = mem_data_pkg::waddr_t'($urandom);
			d = $urandom;
			wr_adr[i] = a;
			push_word(d);
			issue_request(1'b1, a);
			shadow[a]  = d;
			written[a] = 1'b1;
		end
		for (int i = 0; i < N_WRITES; i++) begin
			issue_request(1'b0, wr_adr[i]);
		end
		for (int i = 0; i < N_WRITES; i++) begin
			pop_and_check();
		end

		// never written address reads zero
		a = mem_data_pkg::waddr_t'($urandom);
		while (written[a]) begin
			a = a + 1'b1;
		end
		issue_request(1'b0, a);
		pop_and_check();

		// fill the receive buffer with no pops
		for (int i = 0; i < `BUF_DEPTH; i++) begin
			issue_request(1'b0, mem_data_pkg::waddr_t'($urandom));
		end
		// one more read held off until a pop
		a     = mem_data_pkg::waddr_t'($urandom);
		req_i = 1'b1;
		rw_i  = 1'b0;
		add_i = a;
		repeat (12) begin
			check_value("ready_req_o", 32'(ready_req_o), 0);
			@(negedge clock_bus_i);
		end
		pop_and_check();
		issue_request(1'b0, a);
		for (int i = 0; i < `BUF_DEPTH; i++) begin
			pop_and_check();
		end
		check_value("exception_bus_o", 32'(exception_bus_o), 0);

		// transmit overflow with no write requests
		for (int i = 0; i < `BUF_DEPTH; i++) begin
			check_value("ready_write_o", 32'(ready_write_o), 1);
			push_word($urandom);
		end
		check_value("ready_write_o", 32'(ready_write_o), 0);
		check_value("exception_bus_o", 32'(exception_bus_o), 0);
		push_word($urandom);
		check_value("exception_bus_o", 32'(exception_bus_o),
			32'(`MEM_INT_BUFFER_TX_OVERFLOW));

		// pop from an empty receive buffer
		check_value("ready_read_o", 32'(ready_read_o), 0);
		read_ack_i = 1'b1;
		@(negedge clock_bus_i);
		read_ack_i = 1'b0;
		check_value("exception_bus_o", 32'(exception_bus_o),
			32'(`MEM_INT_BUFFER_TX_OVERFLOW | `MEM_INT_BUFFER_RX_UNDERFLOW));
		repeat (8) @(negedge clock_bus_i);
		check_value("exception_bus_o", 32'(exception_bus_o),
			32'(`MEM_INT_BUFFER_TX_OVERFLOW | `MEM_INT_BUFFER_RX_UNDERFLOW));

		// second reset clears flags and buffers
		apply_reset();

		prop_errs = i_dut.u_props.fail_cnt;
		$display("errors: %0d check, %0d assertion", errors, prop_errs);
		if (errors == 0 && prop_errs == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	// ------------------------------------------------------------
	// watchdog
	// ------------------------------------------------------------
	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("watchdog expired after %0d cycles, the test did not finish",
			WATCHDOG_CYCLES);
		$display("Simulation failed");
		$finish;
	end

endmodule

/* dv/l1_l2_path_props.sv */
`timescale 1ns/100ps

module l1_l2_path_props (
	input logic               clock_bus_i,
	input logic               reset_i,
	input logic               wb_cyc_i,
	input logic               wb_stb_i,
	input logic               wb_ack_i,
	input logic               l2_req_i,
	input mem_ctrl_pkg::exc_t exception_bus_i
);

	// count of failed assertions
	int unsigned fail_cnt = 0;

	// ------------------------------------------------------------
	// wishbone classic between master and store
	// ------------------------------------------------------------

	// cyc and stb stay up together until the ack edge
	stb_held_to_ack: assert property (@(posedge clock_bus_i) disable iff (!reset_i)
		(wb_stb_i && !wb_ack_i) |=> (wb_cyc_i && wb_stb_i))
	else begin
		fail_cnt++;
		$error("wb_cyc or wb_stb dropped before wb_ack");
	end

	// slave answers only an active strobe
	ack_under_stb: assert property (@(posedge clock_bus_i) disable iff (!reset_i)
		wb_ack_i |-> wb_stb_i)
	else begin
		fail_cnt++;
		$error("wb_ack high without wb_stb");
	end

	// single-cycle ack, cycle ends right after it
	ack_one_cycle: assert property (@(posedge clock_bus_i) disable iff (!reset_i)
		wb_ack_i |=> (!wb_ack_i && !wb_stb_i))
	else begin
		fail_cnt++;
		$error("wb_ack longer than one cycle or wb_stb held after ack");
	end

	// request toward L2 is a pulse
	req_is_pulse: assert property (@(posedge clock_bus_i) disable iff (!reset_i)
		l2_req_i |=> !l2_req_i)
	else begin
		fail_cnt++;
		$error("l2_req held for more than one cycle");
	end

	// ------------------------------------------------------------
	// exception bus
	// ------------------------------------------------------------

	// cleared by every reset cycle
	exc_clear_after_reset: assert property (@(posedge clock_bus_i)
		!reset_i |=> (exception_bus_i == '0))
	else begin
		fail_cnt++;
		$error("exception bus not zero after reset");
	end

	// bits are sticky until reset
	exc_sticky: assert property (@(posedge clock_bus_i) disable iff (!reset_i)
		(exception_bus_i != '0) |=>
			((exception_bus_i & $past(exception_bus_i)) == $past(exception_bus_i)))
	else begin
		fail_cnt++;
		$error("exception bit cleared without reset");
	end

endmodule

bind l1_l2_path_top l1_l2_path_props u_props (
	.clock_bus_i     (clock_bus_i),
	.reset_i         (reset_i),
	.wb_cyc_i        (wb_cyc),
	.wb_stb_i        (wb_stb),
	.wb_ack_i        (wb_ack),
	.l2_req_i        (l2_req),
	.exception_bus_i (exception_bus_o)
);

/* design/l1_l2_path_top.sv */
`timescale 1ns/100ps

module l1_l2_path_top (
	// system
	input  logic                 clock_bus_i,
	input  logic                 reset_i,
	output mem_ctrl_pkg::exc_t   exception_bus_o,

	// controller side
	input  logic                 req_i,
	input  logic                 rw_i,
	input  mem_data_pkg::waddr_t add_i,
	input  logic                 write_en_i,
	input  logic                 read_ack_i,
	input  mem_data_pkg::word_t  data_i,
	output logic                 ready_req_o,
	output logic                 ready_write_o,
	output logic                 ready_read_o,
	output mem_data_pkg::word_t  data_o
);

	// ------------------------------------------------------------
	// buffer to master
	// ------------------------------------------------------------
	logic                 l2_req;
	logic                 l2_rw;
	mem_data_pkg::waddr_t l2_add;
	mem_data_pkg::word_t  l2_tx_data;
	logic                 l2_tx_avail;
	logic                 l2_rx_room;
	logic                 l2_ready;
	logic                 l2_tx_pop;
	logic                 l2_rx_valid;
	mem_data_pkg::word_t  l2_rx_data;

	// ------------------------------------------------------------
	// master to store, wishbone classic
	// ------------------------------------------------------------
	logic                 wb_cyc;
	logic                 wb_stb;
	logic                 wb_we;
	mem_data_pkg::waddr_t wb_adr;
	// write data toward the store
	mem_data_pkg::word_t  wb_dat_m2s;
	// read data back to the master
	mem_data_pkg::word_t  wb_dat_s2m;
	logic                 wb_ack;

	txrx_buffer_l2_l1 u_buffer (
		.clock_bus_i     (clock_bus_i),
		.reset_i         (reset_i),
		.exception_bus_o (exception_bus_o),
		.req_i           (req_i),
		.rw_i            (rw_i),
		.add_i           (add_i),
		.write_en_i      (write_en_i),
		.read_ack_i      (read_ack_i),
		.data_i          (data_i),
		.ready_req_o     (ready_req_o),
		.ready_write_o   (ready_write_o),
		.ready_read_o    (ready_read_o),
		.data_o          (data_o),
		.l2_req_o        (l2_req),
		.l2_rw_o         (l2_rw),
		.l2_add_o        (l2_add),
		.l2_tx_data_o    (l2_tx_data),
		.l2_tx_avail_o   (l2_tx_avail),
		.l2_rx_room_o    (l2_rx_room),
		.l2_ready_i      (l2_ready),
		.l2_tx_pop_i     (l2_tx_pop),
		.l2_rx_valid_i   (l2_rx_valid),
		.l2_rx_data_i    (l2_rx_data)
	);

	l2_wb_master u_master (
		.clock_bus_i   (clock_bus_i),
		.reset_i       (reset_i),
		.l2_req_i      (l2_req),
		.l2_rw_i       (l2_rw),
		.l2_add_i      (l2_add),
		.l2_tx_data_i  (l2_tx_data),
		.l2_tx_avail_i (l2_tx_avail),
		.l2_rx_room_i  (l2_rx_room),
		.l2_ready_o    (l2_ready),
		.l2_tx_pop_o   (l2_tx_pop),
		.l2_rx_valid_o (l2_rx_valid),
		.l2_rx_data_o  (l2_rx_data),
		.wb_ack_i      (wb_ack),
		.wb_dat_i      (wb_dat_s2m),
		.wb_cyc_o      (wb_cyc),
		.wb_stb_o      (wb_stb),
		.wb_we_o       (wb_we),
		.wb_adr_o      (wb_adr),
		.wb_dat_o      (wb_dat_m2s)
	);

	l2_store u_store (
		.clock_bus_i (clock_bus_i),
		.reset_i     (reset_i),
		.wb_cyc_i    (wb_cyc),
		.wb_stb_i    (wb_stb),
		.wb_we_i     (wb_we),
		.wb_adr_i    (wb_adr),
		.wb_dat_i    (wb_dat_m2s),
		.wb_ack_o    (wb_ack),
		.wb_dat_o    (wb_dat_s2m)
	);

endmodule

/* design/l2_store.sv */
`timescale 1ns/100ps

`include "mem_defs.svh"

module l2_store (
	input  logic                 clock_bus_i,
	input  logic                 reset_i,

	// wishbone classic slave
	input  logic                 wb_cyc_i,
	input  logic                 wb_stb_i,
	input  logic                 wb_we_i,
	input  mem_data_pkg::waddr_t wb_adr_i,
	input  mem_data_pkg::word_t  wb_dat_i,
	output logic                 wb_ack_o,
	output mem_data_pkg::word_t  wb_dat_o
);

	// stand-in for the real L2 array
	mem_data_pkg::word_t ram_q [`L2_WORDS];

	logic access;

	// ------------------------------------------------------------
	// one wait state then ack for a single cycle
	// ------------------------------------------------------------
	assign access = wb_cyc_i && wb_stb_i;

	always_ff @(posedge clock_bus_i) begin
		if (!reset_i) begin
			wb_ack_o <= 1'b0;
			// unwritten words read back as zero
			for (int i = 0; i < `L2_WORDS; i++) begin
				ram_q[i] <= '0;
			end
		end else begin
			// ack drops on its own after one cycle
			wb_ack_o <= access && !wb_ack_o;
			// write lands at the end of the ack cycle
			if (access && wb_ack_o && wb_we_i) begin
				ram_q[wb_adr_i] <= wb_dat_i;
			end
		end
	end

	// ------------------------------------------------------------
	// read data
	// ------------------------------------------------------------

	// fetched in the wait state, valid alongside ack
	always_ff @(posedge clock_bus_i) begin
		if (access && !wb_ack_o) begin
			wb_dat_o <= ram_q[wb_adr_i];
		end
	end

endmodule

/* design/l2_wb_master.sv */
`timescale 1ns/100ps

module l2_wb_master (
	input  logic                 clock_bus_i,
	input  logic                 reset_i,

	// request and buffer side
	input  logic                 l2_req_i,
	input  logic                 l2_rw_i,
	input  mem_data_pkg::waddr_t l2_add_i,
	input  mem_data_pkg::word_t  l2_tx_data_i,
	input  logic                 l2_tx_avail_i,
	input  logic                 l2_rx_room_i,
	output logic                 l2_ready_o,
	output logic                 l2_tx_pop_o,
	output logic                 l2_rx_valid_o,
	output mem_data_pkg::word_t  l2_rx_data_o,

	// wishbone classic master
	input  logic                 wb_ack_i,
	input  mem_data_pkg::word_t  wb_dat_i,
	output logic                 wb_cyc_o,
	output logic                 wb_stb_o,
	output logic                 wb_we_o,
	output mem_data_pkg::waddr_t wb_adr_o,
	output mem_data_pkg::word_t  wb_dat_o
);

	mem_ctrl_pkg::wbm_state_t state_q;
	mem_ctrl_pkg::wbm_state_t state_d;

	// request held while a write waits for its data
	logic                 pend_q;
	logic                 rw_q;
	mem_data_pkg::waddr_t adr_q;
	mem_data_pkg::word_t  rx_data_q;

	logic has_req;
	logic cur_rw;
	logic start;
	logic in_idle;

	// ------------------------------------------------------------
	// start decision
	// ------------------------------------------------------------
	assign in_idle = (state_q == mem_ctrl_pkg::IDLE);
	assign has_req = l2_req_i || pend_q;
	// fresh pulse wins over the held copy
	assign cur_rw  = l2_req_i ? l2_rw_i : rw_q;
	// a write needs its word in the transmit buffer
	assign start   = has_req && (!cur_rw || l2_tx_avail_i);

	// no new request while one is pending or arriving
	assign l2_ready_o = in_idle && !has_req && l2_rx_room_i;

	// ------------------------------------------------------------
	// state machine
	// ------------------------------------------------------------
	always_comb begin
		state_d = state_q;
		case (state_q)
			mem_ctrl_pkg::IDLE: begin
				if (start) begin
					state_d = mem_ctrl_pkg::CYCLE;
				end
			end
			mem_ctrl_pkg::CYCLE: begin
				if (wb_ack_i) begin
					state_d = mem_ctrl_pkg::DONE;
				end
			end
			mem_ctrl_pkg::DONE: state_d = mem_ctrl_pkg::IDLE;
			default:            state_d = mem_ctrl_pkg::IDLE;
		endcase
	end

	always_ff @(posedge clock_bus_i) begin
		if (!reset_i) begin
			state_q <= mem_ctrl_pkg::IDLE;
			pend_q  <= 1'b0;
			rw_q    <= 1'b0;
		end else begin
			state_q <= state_d;
			if (in_idle) begin
				pend_q <= has_req && !start;
				if (l2_req_i) begin
					rw_q <= l2_rw_i;
				end
			end
		end
	end

	// address capture and read word from the bus
	always_ff @(posedge clock_bus_i) begin
		if (in_idle && l2_req_i) begin
			adr_q <= l2_add_i;
		end
		if (state_q == mem_ctrl_pkg::CYCLE && wb_ack_i && !rw_q) begin
			rx_data_q <= wb_dat_i;
		end
	end

	// ------------------------------------------------------------
	// bus and buffer strobes
	// ------------------------------------------------------------
	assign wb_cyc_o = (state_q == mem_ctrl_pkg::CYCLE);
	assign wb_stb_o = (state_q == mem_ctrl_pkg::CYCLE);
	assign wb_we_o  = rw_q;
	assign wb_adr_o = adr_q;
	// transmit head stays put until the pop in DONE
	assign wb_dat_o = l2_tx_data_i;

	// buffer moves happen one cycle after ack
	assign l2_tx_pop_o   = (state_q == mem_ctrl_pkg::DONE) && rw_q;
	assign l2_rx_valid_o = (state_q == mem_ctrl_pkg::DONE) && !rw_q;
	assign l2_rx_data_o  = rx_data_q;

endmodule

/* design/txrx_buffer_l2_l1.sv */
`timescale 1ns/100ps

`include "mem_defs.svh"

module txrx_buffer_l2_l1 (
	// system
	input  logic                 clock_bus_i,
	input  logic                 reset_i,
	output mem_ctrl_pkg::exc_t   exception_bus_o,

	// controller side
	input  logic                 req_i,
	input  logic                 rw_i,
	input  mem_data_pkg::waddr_t add_i,
	input  logic                 write_en_i,
	input  logic                 read_ack_i,
	input  mem_data_pkg::word_t  data_i,
	output logic                 ready_req_o,
	output logic                 ready_write_o,
	output logic                 ready_read_o,
	output mem_data_pkg::word_t  data_o,

	// L2 side
	output logic                 l2_req_o,
	output logic                 l2_rw_o,
	output mem_data_pkg::waddr_t l2_add_o,
	output mem_data_pkg::word_t  l2_tx_data_o,
	output logic                 l2_tx_avail_o,
	output logic                 l2_rx_room_o,
	input  logic                 l2_ready_i,
	input  logic                 l2_tx_pop_i,
	input  logic                 l2_rx_valid_i,
	input  mem_data_pkg::word_t  l2_rx_data_i
);

	logic req_taken;
	logic tx_full;
	logic tx_empty;
	logic tx_overflow;
	logic rx_full;
	logic rx_empty;
	logic rx_overflow;
	logic rx_underflow;

	// ------------------------------------------------------------
	// request register toward L2
	// ------------------------------------------------------------

	// master readiness goes straight back to the controller
	assign ready_req_o = l2_ready_i;
	assign req_taken   = req_i && ready_req_o;

	// one-cycle pulse per taken request
	always_ff @(posedge clock_bus_i) begin
		if (!reset_i) begin
			l2_req_o <= 1'b0;
			l2_rw_o  <= 1'b0;
		end else begin
			l2_req_o <= req_taken;
			if (req_taken) begin
				l2_rw_o <= rw_i;
			end
		end
	end

	// address only matters with the pulse
	always_ff @(posedge clock_bus_i) begin
		if (req_taken) begin
			l2_add_o <= add_i;
		end
	end

	// ------------------------------------------------------------
	// transmit buffer, controller pushes and master pops
	// ------------------------------------------------------------
	word_fifo #(
		.PTR_W($clog2(`BUF_DEPTH))
	) u_tx_fifo (
		.clock_bus_i (clock_bus_i),
		.reset_i     (reset_i),
		.push_i      (write_en_i),
		.pop_i       (l2_tx_pop_i),
		.data_i      (data_i),
		.data_o      (l2_tx_data_o),
		.count_o     (),
		.full_o      (tx_full),
		.empty_o     (tx_empty),
		.overflow_o  (tx_overflow),
		.underflow_o ()
	);

	assign ready_write_o = !tx_full;
	assign l2_tx_avail_o = !tx_empty;

	// ------------------------------------------------------------
	// receive buffer, master pushes and controller pops
	// ------------------------------------------------------------
	word_fifo #(
		.PTR_W($clog2(`BUF_DEPTH))
	) u_rx_fifo (
		.clock_bus_i (clock_bus_i),
		.reset_i     (reset_i),
		.push_i      (l2_rx_valid_i),
		.pop_i       (read_ack_i),
		.data_i      (l2_rx_data_i),
		.data_o      (data_o),
		.count_o     (),
		.full_o      (rx_full),
		.empty_o     (rx_empty),
		.overflow_o  (rx_overflow),
		.underflow_o (rx_underflow)
	);

	assign ready_read_o = !rx_empty;
	assign l2_rx_room_o = !rx_full;

	// sticky buffer flags merged into one-hot codes
	assign exception_bus_o =
		(tx_overflow  ? `MEM_INT_BUFFER_TX_OVERFLOW  : 4'b0000) |
		(rx_overflow  ? `MEM_INT_BUFFER_RX_OVERFLOW  : 4'b0000) |
		(rx_underflow ? `MEM_INT_BUFFER_RX_UNDERFLOW : 4'b0000);

endmodule

/* design/word_fifo.sv */
`timescale 1ns/100ps

module word_fifo #(
	parameter int PTR_W = $bits(mem_data_pkg::bufptr_t)
) (
	input  logic                  clock_bus_i,
	input  logic                  reset_i,
	input  logic                  push_i,
	input  logic                  pop_i,
	input  mem_data_pkg::word_t   data_i,
	output mem_data_pkg::word_t   data_o,
	output mem_data_pkg::bufcnt_t count_o,
	output logic                  full_o,
	output logic                  empty_o,
	output logic                  overflow_o,
	output logic                  underflow_o
);

	localparam int DEPTH = 1 << PTR_W;

	// storage, no reset needed
	mem_data_pkg::word_t mem_q [DEPTH];

	logic [PTR_W-1:0] wr_ptr_q;
	logic [PTR_W-1:0] rd_ptr_q;
	logic [PTR_W:0]   count_q;
	logic             do_push;
	logic             do_pop;

	// ------------------------------------------------------------
	// status
	// ------------------------------------------------------------
	assign full_o  = (count_q == (PTR_W+1)'(DEPTH));
	assign empty_o = (count_q == '0);
	assign count_o = mem_data_pkg::bufcnt_t'(count_q);

	// head word is always visible
	assign data_o = mem_q[rd_ptr_q];

	// push dropped when full, pop ignored when empty
	assign do_push = push_i && !full_o;
	assign do_pop  = pop_i && !empty_o;

	// ------------------------------------------------------------
	// pointers, count and sticky flags
	// ------------------------------------------------------------
	always_ff @(posedge clock_bus_i) begin
		if (!reset_i) begin
			wr_ptr_q    <= '0;
			rd_ptr_q    <= '0;
			count_q     <= '0;
			overflow_o  <= 1'b0;
			underflow_o <= 1'b0;
		end else begin
			if (do_push) begin
				wr_ptr_q <= wr_ptr_q + 1'b1;
			end
			if (do_pop) begin
				rd_ptr_q <= rd_ptr_q + 1'b1;
			end
			// both at once leave the count alone
			case ({do_push, do_pop})
				2'b10:   count_q <= count_q + 1'b1;
				2'b01:   count_q <= count_q - 1'b1;
				default: count_q <= count_q;
			endcase
			// flags stay up until reset
			if (push_i && full_o) begin
				overflow_o <= 1'b1;
			end
			if (pop_i && empty_o) begin
				underflow_o <= 1'b1;
			end
		end
	end

	// write port
	always_ff @(posedge clock_bus_i) begin
		if (do_push) begin
			mem_q[wr_ptr_q] <= data_i;
		end
	end

endmodule

/* design/mem_ctrl_pkg.sv */
package mem_ctrl_pkg;

	// ------------------------------------------------------------
	// control vectors and state encodings
	// ------------------------------------------------------------

	// merged exception bits of both buffers
	typedef logic [3:0] exc_t;

	// wishbone master states
	// IDLE waits for a request and for write data
	// CYCLE holds cyc and stb until ack
	// DONE moves the word into or out of a buffer
	typedef enum logic [1:0] {
		IDLE  = 2'b00,
		CYCLE = 2'b01,
		DONE  = 2'b10
	} wbm_state_t;

endpackage

/* design/mem_data_pkg.sv */
`include "mem_defs.svh"

package mem_data_pkg;

	// ------------------------------------------------------------
	// data path vectors
	// ------------------------------------------------------------

	// one data word as moved between L1 and L2
	typedef logic [31:0] word_t;

	// word address, no byte offset
	typedef logic [`BW_WORD_ADDR-1:0] waddr_t;

	// read or write index into a buffer
	typedef logic [`BUF_PTR_W-1:0] bufptr_t;

	// occupancy, one bit wider so a full buffer fits
	typedef logic [`BUF_PTR_W:0] bufcnt_t;

endpackage

/* design/mem_defs.svh */
`ifndef MEM_DEFS_SVH
`define MEM_DEFS_SVH

// ------------------------------------------------------------
// address and buffer geometry
// ------------------------------------------------------------

// word address width toward L2
`define BW_WORD_ADDR 8

// entries per transmit or receive buffer
`define BUF_DEPTH 16
// log2 of the buffer depth
`define BUF_PTR_W 4

// words held by the L2 stand-in store
`define L2_WORDS 256

// ------------------------------------------------------------
// exception codes, one-hot, bit 3 reserved
// ------------------------------------------------------------
`define MEM_INT_BUFFER_TX_OVERFLOW  4'b0001
`define MEM_INT_BUFFER_RX_OVERFLOW  4'b0010
`define MEM_INT_BUFFER_RX_UNDERFLOW 4'b0100

`endif
